// File: Makefile
# Verilator build and run for the floppy drive pair testbench
VERILATOR ?= verilator
TOP       ?= tb_flux_drive
FLIST     ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
DATA      ?= bench/flux_input.txt
VFLAGS    ?= --binary --timing --assert

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all run build lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(FLIST) src/*.sv src/*.svh bench/*.sv
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: $(SIM_BIN) $(DATA)
	./$(SIM_BIN) | tee $(LOG)
	@grep -q "TEST RESULT: PASS" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing -f $(FLIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: all.f
+incdir+src
src/flux_pkg.sv
src/apb_drive_regs.sv
src/disk_rotator.sv
src/sony_drive.sv
src/drive_output_mux.sv
src/flux_drive_pair.sv
bench/clock_gen.sv
bench/tb_flux_drive.sv

// File: bench/clock_gen.sv
// ======================================================================
// Testbench clock and reset source, 20 unit period, 4 cycle reset
// ======================================================================
`default_nettype none

module clock_gen (
    output logic CLK_14M,
    output logic RESET
);

    initial begin
        CLK_14M = 1'b0;
        forever #10 CLK_14M = ~CLK_14M;     // Period of 20
    end

    initial begin
        RESET = 1'b1;
        repeat (4) @(posedge CLK_14M);
        RESET <= 1'b0;                      // Released on the fourth edge
    end

endmodule

`default_nettype wire

// File: bench/flux_input.txt
# op addr data expected, fields in hex, T lines name the next test
# W write, C read and compare, N idle cycles, S sense sweep (cfg in data, mask in expected)
# P step pulses (ctrl base in addr, count in data), R wait ready, F flux count on drive addr
T sense_table
S 04 00000000 0000CB4E
S 04 00000001 0000CA4E
S 04 00000004 0000C94E
S 04 00000005 0000C84E
T commands
W 00 00000000 00000000
W 00 0000000C 00000000
W 00 00000000 00000000
C 08 00000000 00000001
W 00 00000008 00000000
W 04 00000000 00000000
W 00 00000002 00000000
W 00 0000000A 00000000
N 00 00000004 00000000
C 08 00000000 00000001
W 04 00000001 00000000
W 00 00000002 00000000
W 00 0000000A 00000000
N 00 00000004 00000000
C 08 00000000 00000004
W 00 00000006 00000000
W 00 0000000E 00000000
W 00 00000002 00000000
N 00 00000004 00000000
C 08 00000000 00000001
T stepping
W 00 00000021 00000000
N 00 00000004 00000000
P 21 00000055 00000000
C 08 00000000 00004F05
P 20 0000005A 00000000
W 00 00000032 00000000
C 08 00000000 00000004
T ready
W 00 00000000 00000000
N 00 00000004 00000000
W 00 00000036 00000000
R 08 00000E00 00000001
T flux_count
F 00 00000700 00000000
T drive_select
P 21 00000005 00000000
W 04 00000003 00000000
W 00 00000040 00000000
W 00 0000004A 00000000
W 00 00000044 00000000
W 00 0000004C 00000000
P 41 00000003 00000000
W 00 00000040 00000000
N 00 00000004 00000000
C 08 00000000 00000305
W 00 00000020 00000000
N 00 00000004 00000000
C 08 00000000 00000504

// File: bench/tb_flux_drive.sv
// ======================================================================
// Testbench for the floppy drive pair
// Replays the data file over APB, models track memories, counts flux
// ======================================================================
`default_nettype none
`include "flux_consts.svh"

module tb_flux_drive import flux_pkg::*; ();

    localparam int CLK_PERIOD  = 20;
    localparam int ROT_CYCLES  = `FD_TRACK_BITS * `FD_BIT_CELL;  // One rotation
    localparam int TRACK_BYTES = (`FD_TRACK_BITS + 7) / 8;

    logic CLK_14M, RESET;
    logic psel, penable, pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata, prdata;
    logic pready, pslverr, flux_transition;
    byte_addr_t [`FD_NUM_DRIVES-1:0]  track_addr;
    logic [`FD_NUM_DRIVES-1:0][7:0]   track_data;

    logic [7:0] track_mem [`FD_NUM_DRIVES][TRACK_BYTES];  // One track per drive
    string lines[$];
    string test_name;
    int    num_tests, test_errors, errors, checks, failed_tests, cycle_count;
    bit    limit_set;

    clock_gen clk_i (.CLK_14M(CLK_14M), .RESET(RESET));

    flux_drive_pair dut_i (
        .CLK_14M(CLK_14M), .RESET(RESET), .psel(psel), .penable(penable),
        .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata), .prdata(prdata),
        .pready(pready), .pslverr(pslverr), .flux_transition(flux_transition),
        .track_addr(track_addr), .track_data(track_data)
    );

    // Track memories answer in the same cycle
    always_comb begin
        for (int d = 0; d < `FD_NUM_DRIVES; d++) begin
            if (int'(track_addr[d]) < TRACK_BYTES)
                track_data[d] = track_mem[d][int'(track_addr[d])];
            else
                track_data[d] = 8'h00;              // Past the end of the track
        end
    end

    always @(posedge CLK_14M) cycle_count <= cycle_count + 1;

    // ==================================================================
    // Helpers
    // ==================================================================
    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        checks++;
        if (exp !== act) begin
            $display("** Error %s: expected %h, actual %h", name, exp, act);
            errors++;
            test_errors++;
        end
    endtask

    // Access phase handshake, no wait states and no slave errors
    task automatic verify_bus_response();
        check_value(test_name, 32'd1, {31'd0, pready});
        check_value(test_name, 32'd0, {31'd0, pslverr});
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
        @(posedge CLK_14M);                         // Setup phase
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b1;
        paddr   <= addr;
        pwdata  <= data;
        @(posedge CLK_14M);                         // Access phase
        penable <= 1'b1;
        @(negedge CLK_14M);
        verify_bus_response();
        @(posedge CLK_14M);
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
        @(posedge CLK_14M);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= addr;
        @(posedge CLK_14M);
        penable <= 1'b1;
        @(negedge CLK_14M);                         // Mid access, data is stable
        data = prdata;
        verify_bus_response();
        @(posedge CLK_14M);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    // One bits of a drive's track, MSB of each byte first
    function automatic int count_ones(input int drive);
        int n;
        n = 0;
        for (int b = 0; b < `FD_TRACK_BITS; b++)
            if (track_mem[drive][b / 8][7 - (b % 8)]) n++;
        return n;
    endfunction

    task automatic sweep_sense(input logic [31:0] cfg, input logic [31:0] mask);
        logic [31:0] rd;
        apb_write(`FD_ADDR_CFG, cfg);
        for (int i = 0; i < 16; i++) begin
            apb_write(`FD_ADDR_CTRL, 32'((((i >> 3) & 1) << 4) | (i & 7)));  // Side, CA2..0
            apb_read(`FD_ADDR_STATUS, rd);
            check_value(test_name, {31'd0, mask[i]}, {31'd0, rd[0]});
        end
    endtask

    task automatic step_pulses(input logic [31:0] base, input logic [31:0] count);
        repeat (count) begin
            apb_write(`FD_ADDR_CTRL, base | 32'h2);      // CA1 up
            apb_write(`FD_ADDR_CTRL, base & ~32'h2);     // CA1 down steps
        end
    endtask

    task automatic wait_ready(input logic [31:0] min_cycles, input logic [31:0] exp);
        logic [31:0] rd;
        int start;
        start = cycle_count;
        rd = '0;
        while (!rd[1] && (cycle_count - start) < 4 * ROT_CYCLES)
            apb_read(`FD_ADDR_STATUS, rd);
        if (!rd[1]) begin
            $display("Test %s: drive never reported ready", test_name);
            errors++;
            test_errors++;
        end
        check_value(test_name, exp, {31'd0, (cycle_count - start) >= int'(min_cycles)});
    endtask

    task automatic count_flux(input int drive, input logic [31:0] cycles);
        int pulses;
        pulses = 0;
        @(posedge CLK_14M);
        repeat (cycles) begin
            @(negedge CLK_14M);
            if (flux_transition) pulses++;
        end
        check_value(test_name, 32'(count_ones(drive)), 32'(pulses));
    endtask

    task automatic close_test();
        if (test_name != "") begin
            if (test_errors == 0) begin
                $display("test %s: ok", test_name);
            end else begin
                $display("test %s: failed with %0d errors", test_name, test_errors);
                failed_tests++;
            end
        end
        test_errors = 0;
    endtask

    task automatic run_line(input string line);
        string op, name;
        logic [31:0] a, d, e, rd;
        if (line.len() < 2 || line.getc(0) == "#") return;
        void'($sscanf(line, "%s", op));
        if (op == "T") begin
            close_test();
            void'($sscanf(line, "%s %s", op, name));
            test_name = name;
            return;
        end
        void'($sscanf(line, "%s %h %h %h", op, a, d, e));
        case (op)
            "W": apb_write(a[7:0], d);
            "C": begin
                apb_read(a[7:0], rd);
                check_value(test_name, e, rd);
            end
            "N": repeat (d) @(posedge CLK_14M);
            "S": sweep_sense(d, e);
            "P": step_pulses(a, d);
            "R": wait_ready(d, e);
            "F": count_flux(int'(a), d);
            default: begin
                $display("Unknown operation %s in data file", op);
                errors++;
            end
        endcase
    endtask

    // ==================================================================
    // Main sequence
    // ==================================================================
    initial begin
        int fd;
        string line;
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= '0;
        pwdata  <= '0;
        cycle_count  = 0;
        errors       = 0;
        checks       = 0;
        failed_tests = 0;
        test_errors  = 0;
        num_tests    = 0;
        test_name    = "";
        limit_set    = 1'b0;
        void'($urandom(31));                        // Fixed seed for the track fill
        for (int dr = 0; dr < `FD_NUM_DRIVES; dr++)
            for (int b = 0; b < TRACK_BYTES; b++)
                track_mem[dr][b] = 8'($urandom);
        fd = $fopen("bench/flux_input.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the data file bench/flux_input.txt");
            errors++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                if ($fgets(line, fd) > 0) lines.push_back(line);
            end
            $fclose(fd);
            foreach (lines[i])
                if (lines[i].len() > 0 && lines[i].getc(0) == "T") num_tests++;
            limit_set = 1'b1;                       // Arms the watchdog
            wait (!RESET);
            @(posedge CLK_14M);
            foreach (lines[i]) run_line(lines[i]);
            close_test();
        end
        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 num_tests, failed_tests, checks, errors);
        if (errors == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

    // Watchdog, four rotations per test
    initial begin
        wait (limit_set);
        #(num_tests * 4 * ROT_CYCLES * CLK_PERIOD);
        $display("Timeout: tests did not finish within %0d cycles",
                 num_tests * 4 * ROT_CYCLES);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: src/apb_drive_regs.sv
// ====================================================================
// APB register block for the floppy drive pair
// Holds CTRL and CFG, makes command and step strobes, returns STATUS
// ====================================================================
`default_nettype none
`include "flux_consts.svh"

module apb_drive_regs import flux_pkg::*; (
    input  logic                       CLK_14M,
    input  logic                       RESET,
    // APB slave
    input  logic                       psel,
    input  logic                       penable,
    input  logic                       pwrite,
    input  logic [7:0]                 paddr,
    input  logic [31:0]                pwdata,
    output logic [31:0]                prdata,
    output logic                       pready,
    output logic                       pslverr,
    // To the drives
    output logic [`FD_NUM_DRIVES-1:0]  cmd_strobe,
    output logic [`FD_NUM_DRIVES-1:0]  step_pulse,
    output logic                       step_dir,
    output sense_idx_t                 sense_idx,
    output logic [`FD_NUM_DRIVES-1:0]  sw_motor,
    output logic [`FD_NUM_DRIVES-1:0]  disk_in,
    output logic [`FD_NUM_DRIVES-1:0]  write_prot,
    output logic                       drive_sel,
    // From the output mux
    input  logic [15:0]                sel_status
);

    phases_t ctrl_phases;                    // CA3..CA0
    logic    ctrl_side;                      // Side-select line
    logic    ctrl_motor;                     // Software motor bit
    logic    ctrl_sel;                       // Drive select
    logic [`FD_NUM_DRIVES-1:0] cfg_disk;     // Disk in place per drive
    logic [`FD_NUM_DRIVES-1:0] cfg_wp;       // Write protect per drive

    logic    wr_ctrl;
    logic    cmd_edge;
    logic    step_edge;

    assign pready  = 1'b1;                   // No wait states
    assign pslverr = 1'b0;

    // Access phase write to CTRL
    assign wr_ctrl = psel && penable && pwrite && (paddr == `FD_ADDR_CTRL);

    // Old against new phase values of this write
    assign cmd_edge  = !ctrl_phases[3] && pwdata[3];     // Phase 3 rises
    assign step_edge = ctrl_phases[1] && !pwdata[1];     // Phase 1 falls

    // ================================================================
    // Registers and strobes
    // ================================================================
    always_ff @(posedge CLK_14M or posedge RESET) begin
        if (RESET) begin
            ctrl_phases <= '0;
            ctrl_side   <= 1'b0;
            ctrl_motor  <= 1'b0;
            ctrl_sel    <= 1'b0;
            cfg_disk    <= '0;
            cfg_wp      <= '0;
            cmd_strobe  <= '0;
            step_pulse  <= '0;
        end else begin
            cmd_strobe <= '0;                // Strobes last one cycle
            step_pulse <= '0;
            if (wr_ctrl) begin
                ctrl_phases <= pwdata[3:0];
                ctrl_side   <= pwdata[4];
                ctrl_motor  <= pwdata[5];
                ctrl_sel    <= pwdata[6];
                // Only the drive named by this write sees the edge
                for (int i = 0; i < `FD_NUM_DRIVES; i++) begin
                    cmd_strobe[i] <= cmd_edge && (pwdata[6] == 1'(i));
                    step_pulse[i] <= step_edge && (pwdata[6] == 1'(i));
                end
            end
            if (psel && penable && pwrite && (paddr == `FD_ADDR_CFG)) begin
                cfg_disk <= pwdata[1:0];
                cfg_wp   <= pwdata[3:2];
            end
        end
    end

    // Drive side signals
    assign step_dir   = ctrl_phases[0];      // CA0 high steps inward
    assign sense_idx  = {ctrl_side, ctrl_phases[2:0]};
    assign drive_sel  = ctrl_sel;
    assign disk_in    = cfg_disk;
    assign write_prot = cfg_wp;
    always_comb begin
        for (int i = 0; i < `FD_NUM_DRIVES; i++)
            sw_motor[i] = ctrl_motor && (ctrl_sel == 1'(i));
    end

    // Read data
    always_comb begin
        case (paddr)
            `FD_ADDR_CTRL:   prdata = {25'd0, ctrl_sel, ctrl_motor, ctrl_side, ctrl_phases};
            `FD_ADDR_CFG:    prdata = {28'd0, cfg_wp, cfg_disk};
            `FD_ADDR_STATUS: prdata = {16'd0, sel_status};
            default:         prdata = 32'd0;
        endcase
    end

    // Enable only ever follows a setup phase of the same transfer
    a_penable_psel: assert property (@(posedge CLK_14M) disable iff (RESET)
        penable |-> psel && $past(psel));

endmodule

`default_nettype wire

// File: src/disk_rotator.sv
// ====================================================================
// Disk rotator for one drive
// Walks the bit cells of the track and emits flux pulses for one bits
// ====================================================================
`default_nettype none
`include "flux_consts.svh"

module disk_rotator import flux_pkg::*; (
    input  logic       CLK_14M,
    input  logic       RESET,
    input  logic       spinning,
    input  logic       disk_in,
    output byte_addr_t track_addr,
    input  logic [7:0] track_data,       // Same-cycle read of track_addr
    output logic       flux,
    output logic       rotation_done
);

    localparam int CELL_W = $clog2(`FD_BIT_CELL + 1);
    localparam logic [CELL_W-1:0] CELL_FULL = CELL_W'(`FD_BIT_CELL);

    logic [CELL_W-1:0] cell_timer;       // Counts down through one bit cell
    bit_pos_t          bit_pos;
    logic              rotating;
    logic              cur_bit;

    assign rotating   = spinning && disk_in;
    assign track_addr = bit_pos[16:3];
    assign cur_bit    = track_data[3'd7 - bit_pos[2:0]];   // MSB first

    always_ff @(posedge CLK_14M or posedge RESET) begin
        if (RESET) begin
            cell_timer    <= CELL_FULL;
            bit_pos       <= '0;
            flux          <= 1'b0;
            rotation_done <= 1'b0;
        end else begin
            flux          <= 1'b0;
            rotation_done <= 1'b0;
            if (rotating) begin
                // Pulse at the start of a cell holding a one
                if ((cell_timer == CELL_FULL) && cur_bit)
                    flux <= 1'b1;
                if (cell_timer == CELL_W'(1)) begin
                    cell_timer <= CELL_FULL;
                    if (bit_pos == bit_pos_t'(`FD_TRACK_BITS - 1)) begin
                        bit_pos       <= '0;
                        rotation_done <= 1'b1;   // Index passed
                    end else begin
                        bit_pos <= bit_pos + 1'b1;
                    end
                end else begin
                    cell_timer <= cell_timer - 1'b1;
                end
            end else begin
                cell_timer <= CELL_FULL;         // Restart a whole cell later
            end
        end
    end

endmodule

`default_nettype wire

// File: src/drive_output_mux.sv
// ====================================================================
// Output mux for the drive pair
// ====================================================================
`default_nettype none
`include "flux_consts.svh"

module drive_output_mux import flux_pkg::*; (
    input  logic                      drive_sel,
    input  logic [`FD_NUM_DRIVES-1:0] sense,
    input  logic [`FD_NUM_DRIVES-1:0] flux,
    input  logic [`FD_NUM_DRIVES-1:0] ready,
    input  logic [`FD_NUM_DRIVES-1:0] spinning,
    input  track_t [`FD_NUM_DRIVES-1:0] track,
    output logic                      flux_transition,
    output logic [15:0]               sel_status
);

    assign flux_transition = flux[drive_sel];

    // STATUS word, track in 14:8, spinning, ready and sense at the bottom
    assign sel_status = {1'b0, track[drive_sel], 5'd0,
                         spinning[drive_sel], ready[drive_sel], sense[drive_sel]};

endmodule

`default_nettype wire

// File: src/flux_consts.svh
// ====================================================================
// Floppy drive pair constants
// Drive geometry, disk timing, Sony codes and APB register map
// ====================================================================
`ifndef FLUX_CONSTS_SVH
`define FLUX_CONSTS_SVH

// Drive geometry
`define FD_NUM_DRIVES        2     // Drives behind the register port
`define FD_MAX_HEAD_POS      319   // 80 tracks in quarter-track units
`define FD_STEP_QUARTERS     4     // One full track per step

// Disk timing in CLK_14M cycles
`define FD_BIT_CELL          28    // 2 us bit cell of a 3.5 inch disk
`define FD_TRACK_BITS        64    // Fixed bits per track
`define FD_SPINUP_ROTATIONS  2     // Rotations before the drive is ready

// Sony commands, latched on the rising edge of phase 3
`define FD_CMD_DIR_IN        4'd0
`define FD_CMD_DIR_OUT       4'd4
`define FD_CMD_MOTOR_ON      4'd2
`define FD_CMD_MOTOR_OFF     4'd6

// Status sense registers with live content, most read low when true
`define FD_SENSE_STEP_DIR    4'h0
`define FD_SENSE_MOTOR       4'h2
`define FD_SENSE_DISK_IN     4'h8
`define FD_SENSE_WPROT       4'h9
`define FD_SENSE_TRACK0      4'hA
`define FD_SENSE_READY       4'hE

// APB register offsets
`define FD_ADDR_CTRL         8'h00
`define FD_ADDR_CFG          8'h04
`define FD_ADDR_STATUS       8'h08

`endif

// File: src/flux_drive_pair.sv
// ====================================================================
// Floppy drive pair top level
// APB register block, two Sony drives and the output mux
// ====================================================================
`default_nettype none
`include "flux_consts.svh"

module flux_drive_pair import flux_pkg::*; (
    input  logic                             CLK_14M,
    input  logic                             RESET,
    input  logic                             psel,
    input  logic                             penable,
    input  logic                             pwrite,
    input  logic [7:0]                       paddr,
    input  logic [31:0]                      pwdata,
    output logic [31:0]                      prdata,
    output logic                             pready,
    output logic                             pslverr,
    output logic                             flux_transition,
    output byte_addr_t [`FD_NUM_DRIVES-1:0]  track_addr,      // One memory per drive
    input  logic [`FD_NUM_DRIVES-1:0][7:0]   track_data
);

    logic [`FD_NUM_DRIVES-1:0] cmd_strobe, step_pulse, sw_motor, disk_in, write_prot;
    logic [`FD_NUM_DRIVES-1:0] drv_sense, drv_flux, drv_ready, drv_spinning;
    track_t [`FD_NUM_DRIVES-1:0] drv_track;
    logic                      step_dir;
    logic                      drive_sel;
    sense_idx_t                sense_idx;
    logic [15:0]               sel_status;

    apb_drive_regs regs_i (
        .CLK_14M    (CLK_14M),    .RESET      (RESET),
        .psel       (psel),       .penable    (penable),
        .pwrite     (pwrite),     .paddr      (paddr),
        .pwdata     (pwdata),     .prdata     (prdata),
        .pready     (pready),     .pslverr    (pslverr),
        .cmd_strobe (cmd_strobe), .step_pulse (step_pulse),
        .step_dir   (step_dir),   .sense_idx  (sense_idx),
        .sw_motor   (sw_motor),   .disk_in    (disk_in),
        .write_prot (write_prot), .drive_sel  (drive_sel),
        .sel_status (sel_status)
    );

    // ================================================================
    // Drives
    // ================================================================
    for (genvar g = 0; g < `FD_NUM_DRIVES; g++) begin : g_drive
        sony_drive drive_i (
            .CLK_14M    (CLK_14M),         .RESET      (RESET),
            .cmd_strobe (cmd_strobe[g]),   .step_pulse (step_pulse[g]),
            .step_dir   (step_dir),        .sense_idx  (sense_idx),
            .sw_motor   (sw_motor[g]),     .disk_in    (disk_in[g]),
            .write_prot (write_prot[g]),   .track_addr (track_addr[g]),
            .track_data (track_data[g]),   .flux       (drv_flux[g]),
            .sense      (drv_sense[g]),    .ready      (drv_ready[g]),
            .spinning   (drv_spinning[g]), .track      (drv_track[g])
        );
    end

    drive_output_mux mux_i (
        .drive_sel       (drive_sel),
        .sense           (drv_sense),
        .flux            (drv_flux),
        .ready           (drv_ready),
        .spinning        (drv_spinning),
        .track           (drv_track),
        .flux_transition (flux_transition),
        .sel_status      (sel_status)
    );

endmodule

`default_nettype wire

// File: src/flux_pkg.sv
// ====================================================================
// Floppy drive pair shared types
// ====================================================================
`default_nettype none

package flux_pkg;

    // Stepper phase lines CA0 to CA3
    typedef logic [3:0] phases_t;

    // Head position in quarter tracks, 0 to 319
    typedef logic [8:0] head_pos_t;

    // Full track number, head position bits 8 to 2
    typedef logic [6:0] track_t;

    // Bit index within the current track
    typedef logic [16:0] bit_pos_t;

    // Byte address into track memory
    typedef logic [13:0] byte_addr_t;

    // Sense register index {side-select, phases 2 to 0}
    typedef logic [3:0] sense_idx_t;

endpackage

`default_nettype wire

// File: src/sony_drive.sv
// ====================================================================
// Sony 3.5 inch drive model
// Commands, head stepper, spin-up to ready and status sense lines
// ====================================================================
`default_nettype none
`include "flux_consts.svh"

module sony_drive import flux_pkg::*; (
    input  logic       CLK_14M,
    input  logic       RESET,
    input  logic       cmd_strobe,       // Phase 3 rising edge for this drive
    input  logic       step_pulse,       // Phase 1 falling edge for this drive
    input  logic       step_dir,         // Phase 0, high steps inward
    input  sense_idx_t sense_idx,
    input  logic       sw_motor,
    input  logic       disk_in,
    input  logic       write_prot,
    output byte_addr_t track_addr,
    input  logic [7:0] track_data,
    output logic       flux,
    output logic       sense,
    output logic       ready,
    output logic       spinning,
    output track_t     track
);

    localparam int SPIN_W = $clog2(`FD_SPINUP_ROTATIONS + 2);

    head_pos_t         head_pos;         // Quarter-track position
    logic              dir_out;          // Command direction, 1 = toward track 0
    logic              motor_cmd;        // Motor state set by Sony commands
    logic              spin_prev;
    logic [SPIN_W-1:0] spin_cnt;         // Index passes left before ready
    logic              rotation_done;

    assign track = head_pos[8:2];

    // ================================================================
    // Command decoder
    // ================================================================
    always_ff @(posedge CLK_14M or posedge RESET) begin
        if (RESET) begin
            dir_out   <= 1'b0;           // Inward after reset
            motor_cmd <= 1'b0;
        end else if (cmd_strobe) begin
            case (sense_idx)             // Side-select high gives 8..15, ignored
                `FD_CMD_DIR_IN:    dir_out <= 1'b0;
                `FD_CMD_DIR_OUT:   dir_out <= 1'b1;
                `FD_CMD_MOTOR_ON:  if (disk_in) motor_cmd <= 1'b1;
                `FD_CMD_MOTOR_OFF: motor_cmd <= 1'b0;
                default: ;
            endcase
        end
    end

    // ================================================================
    // Head stepper
    // ================================================================
    always_ff @(posedge CLK_14M or posedge RESET) begin
        if (RESET) begin
            head_pos <= '0;
        end else if (step_pulse && spinning) begin
            if (step_dir) begin
                // Toward track 79, stops on the last full track
                if (head_pos <= head_pos_t'(`FD_MAX_HEAD_POS - `FD_STEP_QUARTERS))
                    head_pos <= head_pos + head_pos_t'(`FD_STEP_QUARTERS);
            end else if (head_pos >= head_pos_t'(`FD_STEP_QUARTERS)) begin
                head_pos <= head_pos - head_pos_t'(`FD_STEP_QUARTERS);
            end else begin
                head_pos <= '0;          // Clamp at track 0
            end
        end
    end

    // ================================================================
    // Motor and ready
    // ================================================================
    always_ff @(posedge CLK_14M or posedge RESET) begin
        if (RESET) begin
            spinning  <= 1'b0;
            spin_prev <= 1'b0;
            spin_cnt  <= '0;
            ready     <= 1'b0;
        end else begin
            spinning  <= sw_motor || motor_cmd;
            spin_prev <= spinning;
            if (!spinning) begin
                ready    <= 1'b0;        // Drops right after the motor stops
                spin_cnt <= '0;
            end else if (!spin_prev && disk_in) begin
                // First index pass only starts a full rotation
                spin_cnt <= SPIN_W'(`FD_SPINUP_ROTATIONS + 1);
                ready    <= 1'b0;
            end else if (rotation_done && (spin_cnt != '0)) begin
                spin_cnt <= spin_cnt - 1'b1;
                if (spin_cnt == SPIN_W'(1))
                    ready <= 1'b1;       // Last spin-up rotation done
            end
        end
    end

    // Status sense, most lines active low
    always_comb begin
        case (sense_idx)
            `FD_SENSE_STEP_DIR: sense = dir_out;
            `FD_SENSE_MOTOR:    sense = ~motor_cmd;
            `FD_SENSE_DISK_IN:  sense = ~disk_in;
            `FD_SENSE_WPROT:    sense = ~write_prot;
            `FD_SENSE_TRACK0:   sense = (track != '0);       // High when off track 0
            `FD_SENSE_READY:    sense = ~ready;
            4'h1, 4'h3, 4'h6, 4'hB, 4'hF: sense = 1'b1;      // Fixed high lines
            default:            sense = 1'b0;
        endcase
    end

    disk_rotator rotator_i (
        .CLK_14M       (CLK_14M),
        .RESET         (RESET),
        .spinning      (spinning),
        .disk_in       (disk_in),
        .track_addr    (track_addr),
        .track_data    (track_data),
        .flux          (flux),
        .rotation_done (rotation_done)
    );

    // Head never leaves the 80-track range
    a_head_range: assert property (@(posedge CLK_14M) disable iff (RESET)
        head_pos <= head_pos_t'(`FD_MAX_HEAD_POS));

endmodule

`default_nettype wire
